// ==== dcache_age.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_age
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  logic   touch_i,
    input  logic   touch_way_i,
    input  logic   valid0_i,
    input  logic   valid1_i,
    output logic   victim_way_o
);

    age_t age0_q [`DC_SETS];
    age_t age1_q [`DC_SETS];
    age_t cur_age0;
    age_t cur_age1;

    // saturating increment
    function automatic age_t age_inc(input age_t a);
        return (a == age_t'(`DC_AGE_MAX)) ? a : a + 1'b1;
    endfunction

    assign cur_age0 = age0_q[index_i];
    assign cur_age1 = age1_q[index_i];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else if (touch_i) begin
            if (touch_way_i) begin
                age1_q[index_i] <= '0;
                age0_q[index_i] <= age_inc(cur_age0);
            end else begin
                age0_q[index_i] <= '0;
                age1_q[index_i] <= age_inc(cur_age1);
            end
        end
    end

    // empty ways first, then the older way, way 0 on a tie
    always_comb begin
        if (!valid0_i) begin
            victim_way_o = 1'b0;
        end else if (!valid1_i) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = (cur_age1 > cur_age0);
        end
    end

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   rd_i,
    input  logic   wr_i,
    input  addr_t  addr_i,
    input  word_t  wdata_i,
    input  mask_t  mask_i,
    input  logic   hit0_i,
    input  logic   hit1_i,
    input  logic   valid0_i,
    input  logic   valid1_i,
    input  logic   dirty0_i,
    input  logic   dirty1_i,
    input  tag_t   tag0_i,
    input  tag_t   tag1_i,
    input  word_t  rdata0_i,
    input  word_t  rdata1_i,
    input  logic   victim_way_i,
    input  logic   mem_ok_i,
    input  word_t  mem_rdata_i,
    output index_t index_o,
    output tag_t   lookup_tag_o,
    output logic   fill_o,
    output logic   fill_way_o,
    output logic   wr0_o,
    output logic   wr1_o,
    output mask_t  wr_mask_o,
    output word_t  wr_data_o,
    output logic   set_dirty_o,
    output logic   touch_o,
    output logic   touch_way_o,
    output word_t  rdata_o,
    output logic   done_o,
    output logic   mem_rd_o,
    output logic   mem_wr_o,
    output addr_t  mem_addr_o,
    output word_t  mem_wdata_o
);

    dc_state_t state_q;
    mem_op_t   mem_op_q;

    addr_t req_addr_q;
    word_t req_wdata_q;
    mask_t req_mask_q;
    logic  req_wr_q;
    logic  victim_q;
    addr_t mem_addr_q;
    word_t mem_wdata_q;
    word_t rdata_q;

    logic  hit;
    logic  victim_dirty;
    logic  refill_done;
    addr_t wb_addr;
    addr_t refill_addr;

    assign index_o      = req_addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign lookup_tag_o = req_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];

    assign hit          = hit0_i || hit1_i;
    assign victim_dirty = victim_way_i ? (valid1_i && dirty1_i) : (valid0_i && dirty0_i);
    assign refill_done  = (state_q == REFILL) && mem_ok_i;

    // victim line goes back to its own address
    assign wb_addr     = {(victim_way_i ? tag1_i : tag0_i), index_o, {`DC_OFFSET_W{1'b0}}};
    assign refill_addr = {lookup_tag_o, index_o, {`DC_OFFSET_W{1'b0}}};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= IDLE;
            mem_op_q <= MEM_NONE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (rd_i || wr_i) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state_q <= DONE;
                    end else if (victim_dirty) begin
                        state_q  <= WBACK;
                        mem_op_q <= MEM_WRITE;
                    end else begin
                        state_q  <= REFILL;
                        mem_op_q <= MEM_READ;
                    end
                end
                WBACK: begin
                    if (mem_ok_i) begin
                        state_q  <= REFILL;
                        mem_op_q <= MEM_READ;
                    end
                end
                REFILL: begin
                    // lookup again once the line is in
                    if (mem_ok_i) begin
                        state_q  <= LOOKUP;
                        mem_op_q <= MEM_NONE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            req_addr_q  <= addr_i;
            req_wdata_q <= wdata_i;
            req_mask_q  <= mask_i;
            req_wr_q    <= wr_i;
        end
        if ((state_q == LOOKUP) && !hit) begin
            victim_q    <= victim_way_i;
            mem_addr_q  <= victim_dirty ? wb_addr : refill_addr;
            mem_wdata_q <= victim_way_i ? rdata1_i : rdata0_i;
        end
        if ((state_q == WBACK) && mem_ok_i) begin
            mem_addr_q <= refill_addr;
        end
        if ((state_q == LOOKUP) && hit && !req_wr_q) begin
            rdata_q <= hit1_i ? rdata1_i : rdata0_i;
        end
    end

    // store hits and refills write the arrays
    assign fill_o      = refill_done;
    assign fill_way_o  = victim_q;
    assign set_dirty_o = (state_q == LOOKUP) && hit && req_wr_q;
    assign wr0_o       = (set_dirty_o && hit0_i) || (refill_done && !victim_q);
    assign wr1_o       = (set_dirty_o && hit1_i) || (refill_done && victim_q);
    assign wr_mask_o   = refill_done ? {`DC_MASK_W{1'b1}} : req_mask_q;
    assign wr_data_o   = refill_done ? mem_rdata_i : req_wdata_q;

    assign touch_o     = (state_q == LOOKUP) && hit;
    assign touch_way_o = hit1_i;

    assign rdata_o     = rdata_q;
    assign done_o      = (state_q == DONE);
    assign mem_rd_o    = (mem_op_q == MEM_READ);
    assign mem_wr_o    = (mem_op_q == MEM_WRITE);
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_data_array
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  logic   clk,
    input  index_t index_i,
    input  logic   wr_i,
    input  mask_t  mask_i,
    input  word_t  wdata_i,
    output word_t  rdata_o
);

    word_t mem_q [`DC_SETS];

    // byte lanes follow the mask
    always_ff @(posedge clk) begin
        if (wr_i) begin
            for (int b = 0; b < `DC_MASK_W; b++) begin
                if (mask_i[b]) begin
                    mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem_q[index_i];

endmodule

// ==== dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_AGE_W-1:0]   age_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        REFILL,
        DONE
    } dc_state_t;

endpackage

// ==== dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// bus widths
`define DC_ADDR_W   64
`define DC_WORD_W   64
`define DC_MASK_W   8

// cache geometry
`define DC_SETS     64
`define DC_INDEX_W  6
`define DC_OFFSET_W 3

// tag is what remains above index and offset
`define DC_TAG_W    55

// replacement age counters
`define DC_AGE_W    3
`define DC_AGE_MAX  7

`endif

// ==== dcache_tag_array.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  tag_t   lookup_tag_i,
    input  logic   fill_i,
    input  tag_t   fill_tag_i,
    input  logic   set_dirty_i,
    output logic   hit_o,
    output logic   valid_o,
    output logic   dirty_o,
    output tag_t   tag_o
);

    tag_t               tag_q [`DC_SETS];
    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;

    // tag storage
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[index_i] <= fill_tag_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            // fresh line from memory is clean
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= 1'b0;
        end else if (set_dirty_i && hit_o) begin
            // only the matching way takes the store
            dirty_q[index_i] <= 1'b1;
        end
    end

    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tag_q[index_i];

    assign hit_o = valid_o && (tag_o == lookup_tag_i);

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_i,
    input  logic  wr_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    input  mask_t mask_i,
    input  logic  mem_ok_i,
    input  word_t mem_rdata_i,
    output word_t rdata_o,
    output logic  done_o,
    output logic  mem_rd_o,
    output logic  mem_wr_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o
);

    index_t index;
    tag_t   lookup_tag;
    tag_t   tag0;
    tag_t   tag1;
    logic   fill;
    logic   fill_way;
    logic   wr0;
    logic   wr1;
    mask_t  wr_mask;
    word_t  wr_data;
    word_t  rdata0;
    word_t  rdata1;
    logic   set_dirty;
    logic   touch;
    logic   touch_way;
    logic   hit0;
    logic   hit1;
    logic   valid0;
    logic   valid1;
    logic   dirty0;
    logic   dirty1;
    logic   victim_way;

    // way 0
    dcache_tag_array u_tag0 (
        .clk          (clk),
        .rst          (rst),
        .index_i      (index),
        .lookup_tag_i (lookup_tag),
        .fill_i       (fill & ~fill_way),
        .fill_tag_i   (lookup_tag),
        .set_dirty_i  (set_dirty),
        .hit_o        (hit0),
        .valid_o      (valid0),
        .dirty_o      (dirty0),
        .tag_o        (tag0)
    );

    dcache_data_array u_data0 (
        .clk     (clk),
        .index_i (index),
        .wr_i    (wr0),
        .mask_i  (wr_mask),
        .wdata_i (wr_data),
        .rdata_o (rdata0)
    );

    // way 1
    dcache_tag_array u_tag1 (
        .clk          (clk),
        .rst          (rst),
        .index_i      (index),
        .lookup_tag_i (lookup_tag),
        .fill_i       (fill & fill_way),
        .fill_tag_i   (lookup_tag),
        .set_dirty_i  (set_dirty),
        .hit_o        (hit1),
        .valid_o      (valid1),
        .dirty_o      (dirty1),
        .tag_o        (tag1)
    );

    dcache_data_array u_data1 (
        .clk     (clk),
        .index_i (index),
        .wr_i    (wr1),
        .mask_i  (wr_mask),
        .wdata_i (wr_data),
        .rdata_o (rdata1)
    );

    dcache_age u_age (
        .clk          (clk),
        .rst          (rst),
        .index_i      (index),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .valid0_i     (valid0),
        .valid1_i     (valid1),
        .victim_way_o (victim_way)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rd_i         (rd_i),
        .wr_i         (wr_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .mask_i       (mask_i),
        .hit0_i       (hit0),
        .hit1_i       (hit1),
        .valid0_i     (valid0),
        .valid1_i     (valid1),
        .dirty0_i     (dirty0),
        .dirty1_i     (dirty1),
        .tag0_i       (tag0),
        .tag1_i       (tag1),
        .rdata0_i     (rdata0),
        .rdata1_i     (rdata1),
        .victim_way_i (victim_way),
        .mem_ok_i     (mem_ok_i),
        .mem_rdata_i  (mem_rdata_i),
        .index_o      (index),
        .lookup_tag_o (lookup_tag),
        .fill_o       (fill),
        .fill_way_o   (fill_way),
        .wr0_o        (wr0),
        .wr1_o        (wr1),
        .wr_mask_o    (wr_mask),
        .wr_data_o    (wr_data),
        .set_dirty_o  (set_dirty),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .rdata_o      (rdata_o),
        .done_o       (done_o),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

// ==== flist.f ====
+incdir+.
mem_bus_pkg.sv
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_age.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_props.sv
tb_dcache.sv

// ==== mem_bus_pkg.sv ====
`include "dcache_settings.svh"

package mem_bus_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_MASK_W-1:0] mask_t;

    // memory side request kind
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

endpackage

// ==== tb_dcache.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module tb_dcache
    import dcache_pkg::*, mem_bus_pkg::*;
;

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40;

    logic  clk = 1'b0;
    logic  rst;
    logic  rd_i;
    logic  wr_i;
    addr_t addr_i;
    word_t wdata_i;
    mask_t mask_i;
    logic  mem_ok_i;
    word_t mem_rdata_i;
    word_t rdata_o;
    logic  done_o;
    logic  mem_rd_o;
    logic  mem_wr_o;
    addr_t mem_addr_o;
    word_t mem_wdata_o;

    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;
    int          hit_cnt = 0;

    // reference model of cache state and both memory views
    tag_t  tag_m [2][`DC_SETS];
    bit    vld_m [2][`DC_SETS];
    bit    dty_m [2][`DC_SETS];
    int    age_m [2][`DC_SETS];
    word_t arch_mem [addr_t];
    word_t back_mem [addr_t];
    tag_t  tag_pool [3] = '{55'h15, 55'h3_c0de, 55'h7f_0000_0000_00a1};

    // expected memory traffic in request order
    bit    exp_wr_q [$];
    addr_t exp_addr_q [$];
    word_t exp_data_q [$];

    logic  mem_busy = 1'b0;
    logic  ok_sent = 1'b0;
    int    mem_wait;

    dcache_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd_i),
        .wr_i        (wr_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .mask_i      (mask_i),
        .mem_ok_i    (mem_ok_i),
        .mem_rdata_i (mem_rdata_i),
        .rdata_o     (rdata_o),
        .done_o      (done_o),
        .mem_rd_o    (mem_rd_o),
        .mem_wr_o    (mem_wr_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

    bind dcache_ctrl tb_dcache_props u_props (
        .clk      (clk),
        .rst      (rst),
        .done_i   (done_o),
        .mem_rd_i (mem_rd_o),
        .mem_wr_i (mem_wr_o),
        .mem_ok_i (mem_ok_i)
    );

    always #2 clk = ~clk;

    task abort_run;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one step per bit taken
    task automatic draw(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // unwritten words read as their own address
    function automatic word_t arch_read(input addr_t a);
        return arch_mem.exists(a) ? arch_mem[a] : a;
    endfunction

    function automatic word_t backing_read(input addr_t a);
        return back_mem.exists(a) ? back_mem[a] : a;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wd, input mask_t m);
        word_t w;
        w = old;
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                w[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic touch_age(input int s, input int w);
        age_m[w][s] = 0;
        if (age_m[1-w][s] < `DC_AGE_MAX) begin
            age_m[1-w][s]++;
        end
    endtask

    // memory responder for one rising edge
    task automatic serve_memory;
        logic [63:0] dly;
        if (ok_sent) begin
            // request lines still show the answered op this edge
            mem_ok_i <= 1'b0;
            ok_sent = 1'b0;
        end else if (!mem_busy && (mem_rd_o || mem_wr_o)) begin
            if (exp_wr_q.size() == 0) begin
                $display("unexpected memory request at %0t where the model predicts a hit",
                         $time);
                abort_run();
            end
            check_value("mem_wr_o", mem_wr_o, exp_wr_q[0]);
            check_value("mem_rd_o", mem_rd_o, !exp_wr_q[0]);
            check_value("mem_addr_o", mem_addr_o, exp_addr_q[0]);
            if (exp_wr_q[0]) begin
                check_value("mem_wdata_o", mem_wdata_o, exp_data_q[0]);
                back_mem[mem_addr_o] = mem_wdata_o;
            end
            void'(exp_wr_q.pop_front());
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            draw(2, dly);
            mem_wait = int'(dly) + 1;
            mem_busy = 1'b1;
        end
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_rdata_i <= backing_read(mem_addr_o);
                mem_ok_i    <= 1'b1;
                ok_sent = 1'b1;
                mem_busy = 1'b0;
            end
        end
    endtask

    task automatic run_request;
        logic [63:0] r;
        logic        is_store;
        index_t      idx;
        tag_t        tag;
        addr_t       addr;
        addr_t       line_addr;
        addr_t       victim_addr;
        word_t       wdata;
        mask_t       mask;
        word_t       exp_rdata;
        int          way;
        logic        hit;
        int          cycles;
        logic        got_done;

        draw(1, r);
        is_store = r[0];
        draw(2, r);
        idx = index_t'(r[1:0]);
        draw(2, r);
        tag = tag_pool[r[1:0] % 3];
        draw(3, r);
        addr = {tag, idx, r[2:0]};
        draw(64, r);
        wdata = r;
        draw(8, r);
        mask = r[7:0];
        line_addr = {tag, idx, 3'b000};
        exp_rdata = '0;

        hit = 1'b1;
        if (vld_m[0][idx] && tag_m[0][idx] == tag) begin
            way = 0;
        end else if (vld_m[1][idx] && tag_m[1][idx] == tag) begin
            way = 1;
        end else begin
            hit = 1'b0;
            if (!vld_m[0][idx]) begin
                way = 0;
            end else if (!vld_m[1][idx]) begin
                way = 1;
            end else begin
                way = (age_m[1][idx] > age_m[0][idx]) ? 1 : 0;
            end
            // dirty victim goes back first
            if (vld_m[way][idx] && dty_m[way][idx]) begin
                victim_addr = {tag_m[way][idx], idx, 3'b000};
                exp_wr_q.push_back(1'b1);
                exp_addr_q.push_back(victim_addr);
                exp_data_q.push_back(arch_read(victim_addr));
            end
            exp_wr_q.push_back(1'b0);
            exp_addr_q.push_back(line_addr);
            exp_data_q.push_back('0);
            tag_m[way][idx] = tag;
            vld_m[way][idx] = 1'b1;
            dty_m[way][idx] = 1'b0;
        end
        touch_age(idx, way);
        if (is_store) begin
            dty_m[way][idx] = 1'b1;
            arch_mem[line_addr] = merge_bytes(arch_read(line_addr), wdata, mask);
        end else begin
            exp_rdata = arch_read(line_addr);
        end

        @(posedge clk);
        rd_i    <= !is_store;
        wr_i    <= is_store;
        addr_i  <= addr;
        wdata_i <= wdata;
        mask_i  <= mask;
        // acceptance edge
        @(posedge clk);
        cycles = 0;
        got_done = 1'b0;
        while (!got_done) begin
            @(posedge clk);
            cycles++;
            serve_memory();
            got_done = done_o;
        end
        rd_i <= 1'b0;
        wr_i <= 1'b0;

        check_value("pending memory requests", exp_wr_q.size(), 0);
        if (hit) begin
            hit_cnt++;
            check_value("hit latency", cycles, 2);
        end
        if (!is_store) begin
            check_value("rdata_o", rdata_o, exp_rdata);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request never completed", cycle_cnt);
            abort_run();
        end else if (u_dut.u_ctrl.u_props.fail_cnt != 0) begin
            $display("a bus protocol assertion failed at %0t", $time);
            abort_run();
        end
    end

    initial begin
        rst         = 1'b0;
        rd_i        = 1'b0;
        wr_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        mask_i      = '0;
        mem_ok_i    = 1'b0;
        mem_rdata_i = '0;
        lfsr_q      = 16'd19564;

        repeat (16) @(posedge clk);
        rst <= 1'b1;

        // quiet bus before the first request
        repeat (4) begin
            @(posedge clk);
            check_value("done_o", done_o, 0);
            check_value("mem_rd_o", mem_rd_o, 0);
            check_value("mem_wr_o", mem_wr_o, 0);
        end

        for (int n = 0; n < NUM_REQ; n++) begin
            run_request();
        end
        repeat (2) @(posedge clk);

        $display("%0d requests, %0d hits", NUM_REQ, hit_cnt);
        if (u_dut.u_ctrl.u_props.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_dcache_props.sv ====
`timescale 1ns/100ps

module tb_dcache_props (
    input  logic clk,
    input  logic rst,
    input  logic done_i,
    input  logic mem_rd_i,
    input  logic mem_wr_i,
    input  logic mem_ok_i
);

    // read by the testbench top to stop the run
    int unsigned fail_cnt = 0;

    one_mem_op: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd_i && mem_wr_i))
        else begin
            $error("memory read and write requested in the same cycle");
            fail_cnt++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_i |=> !done_i)
        else begin
            $error("done held for more than one cycle");
            fail_cnt++;
        end

    // request level must hold until memory answers
    rd_held: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_i && !mem_ok_i) |=> mem_rd_i)
        else begin
            $error("memory read dropped before ok");
            fail_cnt++;
        end

    wr_held: assert property (@(posedge clk) disable iff (!rst)
        (mem_wr_i && !mem_ok_i) |=> mem_wr_i)
        else begin
            $error("memory write dropped before ok");
            fail_cnt++;
        end

endmodule
